//--- hw/rob_core_params.svh
`ifndef ROB_CORE_PARAMS_SVH
`define ROB_CORE_PARAMS_SVH

// Instructions offered, accepted and retired per cycle.
`define ROB_N 2

// Reorder buffer depth, a power of two so indices wrap naturally.
`define ROB_SZ 8

// Width of registers, operands and results.
`define XLEN 16

// Architectural registers, addressed by 3-bit fields.
`define NUM_REGS 8

// Width of a per-cycle count from 0 to ROB_N.
`define ROB_CNT_W ($clog2(`ROB_N + 1))

// Width of an occupancy count from 0 to ROB_SZ.
`define ROB_SPOT_W ($clog2(`ROB_SZ + 1))

`endif

//--- hw/rob_core_pkg.sv
`include "rob_core_params.svh"

package rob_core_pkg;

    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        AND  = 3'd2,
        XOR  = 3'd3,
        MUL  = 3'd4,                  // Goes down the three-stage multiplier.
        ADDI = 3'd5,
        LUI  = 3'd6,                  // Immediate lands in bits 15 to 9.
        NOP  = 3'd7
    } op_e;

    // Register-register layout.
    typedef struct packed {
        op_e        opcode;
        logic [2:0] rd;
        logic [2:0] rs1;
        logic [2:0] rs2;
        logic [3:0] unused;
    } r_form_t;

    // Register-immediate layout, shared by ADDI and LUI.
    typedef struct packed {
        op_e               opcode;
        logic [2:0]        rd;
        logic [2:0]        rs1;
        logic signed [6:0] imm;
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } inst_word_u;

    typedef struct packed {
        logic [2:0]       rd;
        logic             writes_reg;   // Clear for NOP.
        logic             complete;     // Set once the result is back.
        logic [`XLEN-1:0] value;
    } rob_entry_t;

    typedef logic [$clog2(`ROB_SZ)-1:0] rob_idx_t;

endpackage

//--- hw/inst_decode.sv
`timescale 1ns/1ns
`include "rob_core_params.svh"

module inst_decode (
    input  logic                        clock,
    input  logic                        reset,
    input  rob_core_pkg::inst_word_u    inst_word [`ROB_N],
    input  logic [`ROB_CNT_W-1:0]       inst_count,
    input  logic [`ROB_SPOT_W-1:0]      spots,
    input  rob_core_pkg::rob_idx_t      tail,
    input  logic [`XLEN-1:0]            reg_value [`NUM_REGS],
    input  logic [`NUM_REGS-1:0]        release_mask,
    output logic [`ROB_CNT_W-1:0]       inst_taken,
    output rob_core_pkg::rob_entry_t    alloc_entry [`ROB_N],
    output logic [`ROB_CNT_W-1:0]       alloc_count,
    output logic [`ROB_N-1:0]           issue_valid,
    output rob_core_pkg::op_e           issue_op [`ROB_N],
    output logic [`XLEN-1:0]            issue_a [`ROB_N],
    output logic [`XLEN-1:0]            issue_b [`ROB_N],
    output rob_core_pkg::rob_idx_t      issue_idx [`ROB_N]
);
    import rob_core_pkg::*;

    localparam int CNT_W  = `ROB_CNT_W;
    localparam int SPOT_W = `ROB_SPOT_W;
    localparam int IDX_W  = $bits(rob_idx_t);

    logic [`NUM_REGS-1:0] busy;                 // Destinations still in flight.
    logic [`NUM_REGS-1:0] group_dest;           // Destinations accepted this cycle.
    logic [`ROB_N-1:0]    uses_rs1;
    logic [`ROB_N-1:0]    uses_rs2;
    logic [`ROB_N-1:0]    writes_rd;
    logic [`ROB_N-1:0]    hazard;
    op_e                  op [`ROB_N];
    logic [2:0]           rd [`ROB_N];
    logic [2:0]           rs1 [`ROB_N];
    logic [2:0]           rs2 [`ROB_N];
    logic [`XLEN-1:0]     src_b [`ROB_N];
    logic [CNT_W-1:0]     taken;
    logic                 run;

    always_comb begin
        for (int i = 0; i < `ROB_N; i++) begin
            op[i]        = inst_word[i].r_form.opcode;
            rd[i]        = inst_word[i].r_form.rd;
            rs1[i]       = inst_word[i].r_form.rs1;
            rs2[i]       = inst_word[i].r_form.rs2;
            uses_rs1[i]  = (op[i] != LUI) && (op[i] != NOP);
            uses_rs2[i]  = uses_rs1[i] && (op[i] != ADDI);
            writes_rd[i] = (op[i] != NOP);
            case (op[i])
                ADDI:    src_b[i] = {{(`XLEN - 7){inst_word[i].i_form.imm[6]}},
                                     inst_word[i].i_form.imm};
                LUI:     src_b[i] = `XLEN'({inst_word[i].i_form.imm, 9'd0});
                default: src_b[i] = reg_value[rs2[i]];
            endcase
        end
    end

    // Take the longest clean prefix; the first stalled word ends the run.
    always_comb begin
        taken      = '0;
        run        = 1'b1;
        group_dest = '0;
        for (int i = 0; i < `ROB_N; i++) begin
            hazard[i] = (uses_rs1[i] && (busy[rs1[i]] || group_dest[rs1[i]]))
                     || (uses_rs2[i] && (busy[rs2[i]] || group_dest[rs2[i]]))
                     || (writes_rd[i] && (busy[rd[i]] || group_dest[rd[i]]));
            if (run && !hazard[i] && (CNT_W'(i) < inst_count) && (SPOT_W'(i) < spots)) begin
                taken = taken + CNT_W'(1);
                if (writes_rd[i]) begin
                    group_dest[rd[i]] = 1'b1;
                end
            end else begin
                run = 1'b0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `ROB_N; i++) begin
            alloc_entry[i].rd         = rd[i];
            alloc_entry[i].writes_reg = writes_rd[i];
            alloc_entry[i].complete   = 1'b0;         // The ROB decides this at write.
            alloc_entry[i].value      = '0;
            issue_valid[i] = (CNT_W'(i) < taken) && writes_rd[i];   // NOPs need no lane.
            issue_op[i]    = op[i];
            issue_a[i]     = reg_value[rs1[i]];
            issue_b[i]     = src_b[i];
            issue_idx[i]   = tail + IDX_W'(i);      // Wraps at ROB_SZ.
        end
    end

    assign inst_taken  = taken;
    assign alloc_count = taken;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~release_mask) | group_dest;   // A new claim beats a release.
        end
    end

endmodule

//--- hw/rob.sv
`timescale 1ns/1ns
`include "rob_core_params.svh"

module rob (
    input  logic                        clock,
    input  logic                        reset,
    input  rob_core_pkg::rob_entry_t    alloc_entry [`ROB_N],
    input  logic [`ROB_CNT_W-1:0]       alloc_count,
    input  logic [`ROB_N-1:0]           alu_done,
    input  rob_core_pkg::rob_idx_t      alu_idx [`ROB_N],
    input  logic [`XLEN-1:0]            alu_value [`ROB_N],
    input  logic [`ROB_N-1:0]           mul_done,
    input  rob_core_pkg::rob_idx_t      mul_idx [`ROB_N],
    input  logic [`XLEN-1:0]            mul_value [`ROB_N],
    input  logic [`ROB_CNT_W-1:0]       retire_count,
    output logic [`ROB_SPOT_W-1:0]      spots,
    output rob_core_pkg::rob_idx_t      tail,
    output rob_core_pkg::rob_entry_t    head_entry [`ROB_N],
    output logic [`ROB_N-1:0]           head_valid
);
    import rob_core_pkg::*;

    localparam int CNT_W  = `ROB_CNT_W;
    localparam int SPOT_W = `ROB_SPOT_W;
    localparam int IDX_W  = $bits(rob_idx_t);

    rob_entry_t          entries [`ROB_SZ];
    rob_entry_t          born [`ROB_N];
    rob_idx_t            head;
    logic [SPOT_W-1:0]   count;             // Occupied entries.

    assign spots = SPOT_W'(`ROB_SZ) - count;

    // A NOP has nothing to wait for, so it is written already complete.
    always_comb begin
        for (int i = 0; i < `ROB_N; i++) begin
            born[i]          = alloc_entry[i];
            born[i].complete = !alloc_entry[i].writes_reg;
        end
    end

    // Allocation only targets free slots and completions only occupied ones,
    // so the writes below never collide.
    always_ff @(posedge clock) begin
        for (int i = 0; i < `ROB_N; i++) begin
            if (CNT_W'(i) < alloc_count) begin
                entries[tail + IDX_W'(i)] <= born[i];
            end
            if (alu_done[i]) begin
                entries[alu_idx[i]].complete <= 1'b1;
                entries[alu_idx[i]].value    <= alu_value[i];
            end
            if (mul_done[i]) begin
                entries[mul_idx[i]].complete <= 1'b1;
                entries[mul_idx[i]].value    <= mul_value[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + IDX_W'(retire_count);     // Power-of-two depth wraps.
            tail  <= tail + IDX_W'(alloc_count);
            count <= count + SPOT_W'(alloc_count) - SPOT_W'(retire_count);
        end
    end

    // Oldest entries, read straight from the array.
    always_comb begin
        for (int i = 0; i < `ROB_N; i++) begin
            head_entry[i] = entries[head + IDX_W'(i)];
            head_valid[i] = SPOT_W'(i) < count;
        end
    end

endmodule

//--- hw/alu_execute.sv
`timescale 1ns/1ns
`include "rob_core_params.svh"

module alu_execute (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`ROB_N-1:0]           issue_valid,
    input  rob_core_pkg::op_e           issue_op [`ROB_N],
    input  logic [`XLEN-1:0]            issue_a [`ROB_N],
    input  logic [`XLEN-1:0]            issue_b [`ROB_N],
    input  rob_core_pkg::rob_idx_t      issue_idx [`ROB_N],
    output logic [`ROB_N-1:0]           alu_done,
    output rob_core_pkg::rob_idx_t      alu_idx [`ROB_N],
    output logic [`XLEN-1:0]            alu_value [`ROB_N],
    output logic [`ROB_N-1:0]           mul_done,
    output rob_core_pkg::rob_idx_t      mul_idx [`ROB_N],
    output logic [`XLEN-1:0]            mul_value [`ROB_N]
);
    import rob_core_pkg::*;

    logic [`ROB_N-1:0] is_mul;
    logic [`XLEN-1:0]  alu_result [`ROB_N];
    logic [`ROB_N-1:0] m1_valid;            // Operands captured.
    logic [`ROB_N-1:0] m2_valid;            // Product formed.
    rob_idx_t          m1_idx [`ROB_N];
    rob_idx_t          m2_idx [`ROB_N];
    logic [`XLEN-1:0]  m1_a [`ROB_N];
    logic [`XLEN-1:0]  m1_b [`ROB_N];
    logic [`XLEN-1:0]  m2_prod [`ROB_N];

    always_comb begin
        for (int i = 0; i < `ROB_N; i++) begin
            is_mul[i] = issue_valid[i] && (issue_op[i] == MUL);
            case (issue_op[i])
                ADD, ADDI: alu_result[i] = issue_a[i] + issue_b[i];
                SUB:       alu_result[i] = issue_a[i] - issue_b[i];
                AND:       alu_result[i] = issue_a[i] & issue_b[i];
                XOR:       alu_result[i] = issue_a[i] ^ issue_b[i];
                LUI:       alu_result[i] = issue_b[i];     // Decode already shifted it.
                default:   alu_result[i] = '0;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_done <= '0;
            m1_valid <= '0;
            m2_valid <= '0;
            mul_done <= '0;
        end else begin
            alu_done <= issue_valid & ~is_mul;
            m1_valid <= is_mul;
            m2_valid <= m1_valid;
            mul_done <= m2_valid;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `ROB_N; i++) begin
            alu_idx[i]   <= issue_idx[i];
            alu_value[i] <= alu_result[i];
            m1_idx[i]    <= issue_idx[i];
            m1_a[i]      <= issue_a[i];
            m1_b[i]      <= issue_b[i];
            m2_idx[i]    <= m1_idx[i];
            m2_prod[i]   <= m1_a[i] * m1_b[i];      // Only the low XLEN bits are kept.
            mul_idx[i]   <= m2_idx[i];
            mul_value[i] <= m2_prod[i];
        end
    end

endmodule

//--- hw/retire.sv
`timescale 1ns/1ns
`include "rob_core_params.svh"

module retire (
    input  logic                        clock,
    input  logic                        reset,
    input  rob_core_pkg::rob_entry_t    head_entry [`ROB_N],
    input  logic [`ROB_N-1:0]           head_valid,
    output logic [`ROB_CNT_W-1:0]       retire_count,
    output logic [`XLEN-1:0]            reg_value [`NUM_REGS],
    output logic [`NUM_REGS-1:0]        release_mask,
    output logic [`ROB_N-1:0]           commit_valid,
    output logic [2:0]                  commit_rd [`ROB_N],
    output logic [`XLEN-1:0]            commit_value [`ROB_N]
);
    localparam int CNT_W = `ROB_CNT_W;

    logic [`ROB_N-1:0] retiring;
    logic [`ROB_N-1:0] next_valid;
    logic [2:0]        next_rd [`ROB_N];
    logic [`XLEN-1:0]  next_value [`ROB_N];
    logic              run;
    int                slot;                // Next free commit lane.

    always_comb begin
        retire_count = '0;
        retiring     = '0;
        release_mask = '0;
        next_valid   = '0;
        run          = 1'b1;
        slot         = 0;
        for (int i = 0; i < `ROB_N; i++) begin
            next_rd[i]    = '0;
            next_value[i] = '0;
        end
        for (int i = 0; i < `ROB_N; i++) begin
            if (run && head_valid[i] && head_entry[i].complete) begin
                retiring[i]  = 1'b1;
                retire_count = retire_count + CNT_W'(1);
                if (head_entry[i].writes_reg) begin
                    release_mask[head_entry[i].rd] = 1'b1;
                    next_valid[slot] = 1'b1;    // Packed low so lane 1 implies lane 0.
                    next_rd[slot]    = head_entry[i].rd;
                    next_value[slot] = head_entry[i].value;
                    slot = slot + 1;
                end
            end else begin
                run = 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                reg_value[r] <= '0;
            end
            commit_valid <= '0;
        end else begin
            // Lanes go in program order, so the younger write to a register lands last.
            for (int i = 0; i < `ROB_N; i++) begin
                if (retiring[i] && head_entry[i].writes_reg) begin
                    reg_value[head_entry[i].rd] <= head_entry[i].value;
                end
            end
            commit_valid <= next_valid;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `ROB_N; i++) begin
            commit_rd[i]    <= next_rd[i];
            commit_value[i] <= next_value[i];
        end
    end

endmodule

//--- hw/rob_core_top.sv
`timescale 1ns/1ns
`include "rob_core_params.svh"

module rob_core_top (
    input  logic                        clock,
    input  logic                        reset,
    input  rob_core_pkg::inst_word_u    inst_word [`ROB_N],
    input  logic [`ROB_CNT_W-1:0]       inst_count,
    output logic [`ROB_CNT_W-1:0]       inst_taken,
    output logic [`ROB_N-1:0]           commit_valid,
    output logic [2:0]                  commit_rd [`ROB_N],
    output logic [`XLEN-1:0]            commit_value [`ROB_N]
);
    import rob_core_pkg::*;

    // Decode and ROB.
    rob_entry_t             alloc_entry [`ROB_N];
    logic [`ROB_CNT_W-1:0]  alloc_count;
    logic [`ROB_SPOT_W-1:0] spots;
    rob_idx_t               tail;

    // Issue lanes.
    logic [`ROB_N-1:0]      issue_valid;
    op_e                    issue_op [`ROB_N];
    logic [`XLEN-1:0]       issue_a [`ROB_N];
    logic [`XLEN-1:0]       issue_b [`ROB_N];
    rob_idx_t               issue_idx [`ROB_N];

    // Completions.
    logic [`ROB_N-1:0]      alu_done;
    rob_idx_t               alu_idx [`ROB_N];
    logic [`XLEN-1:0]       alu_value [`ROB_N];
    logic [`ROB_N-1:0]      mul_done;
    rob_idx_t               mul_idx [`ROB_N];
    logic [`XLEN-1:0]       mul_value [`ROB_N];

    // Head window and architectural state.
    rob_entry_t             head_entry [`ROB_N];
    logic [`ROB_N-1:0]      head_valid;
    logic [`ROB_CNT_W-1:0]  retire_count;
    logic [`XLEN-1:0]       reg_value [`NUM_REGS];
    logic [`NUM_REGS-1:0]   release_mask;

    inst_decode i_inst_decode (
        .clock        (clock),
        .reset        (reset),
        .inst_word    (inst_word),
        .inst_count   (inst_count),
        .spots        (spots),
        .tail         (tail),
        .reg_value    (reg_value),
        .release_mask (release_mask),
        .inst_taken   (inst_taken),
        .alloc_entry  (alloc_entry),
        .alloc_count  (alloc_count),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_idx    (issue_idx)
    );

    rob i_rob (
        .clock        (clock),
        .reset        (reset),
        .alloc_entry  (alloc_entry),
        .alloc_count  (alloc_count),
        .alu_done     (alu_done),
        .alu_idx      (alu_idx),
        .alu_value    (alu_value),
        .mul_done     (mul_done),
        .mul_idx      (mul_idx),
        .mul_value    (mul_value),
        .retire_count (retire_count),
        .spots        (spots),
        .tail         (tail),
        .head_entry   (head_entry),
        .head_valid   (head_valid)
    );

    alu_execute i_alu_execute (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_idx    (issue_idx),
        .alu_done     (alu_done),
        .alu_idx      (alu_idx),
        .alu_value    (alu_value),
        .mul_done     (mul_done),
        .mul_idx      (mul_idx),
        .mul_value    (mul_value)
    );

    retire i_retire (
        .clock        (clock),
        .reset        (reset),
        .head_entry   (head_entry),
        .head_valid   (head_valid),
        .retire_count (retire_count),
        .reg_value    (reg_value),
        .release_mask (release_mask),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

endmodule

//--- test/rob_core_properties.sv
`timescale 1ns/1ns
`include "rob_core_params.svh"

module rob_core_properties (
    input logic                  clock,
    input logic                  reset,
    input logic [`ROB_CNT_W-1:0] inst_count,
    input logic [`ROB_CNT_W-1:0] inst_taken,
    input logic [`ROB_N-1:0]     commit_valid
);

    // Decode can only take words that were offered.
    property taken_within_offer;
        @(posedge clock) disable iff (reset)
            inst_taken <= inst_count;
    endproperty

    // The first cycle out of reset shows no commit.
    property quiet_after_reset;
        @(posedge clock) $fell(reset) |-> (commit_valid == '0);
    endproperty

    assert property (taken_within_offer)
        else $error("inst_taken %0d exceeds inst_count %0d", inst_taken, inst_count);

    assert property (quiet_after_reset)
        else $error("commit_valid 0x%h right after reset", commit_valid);

    // Commits are packed into the low lanes.
    for (genvar lane = 1; lane < `ROB_N; lane++) begin : g_commit_order
        assert property (@(posedge clock) disable iff (reset)
                         commit_valid[lane] |-> commit_valid[lane - 1])
            else $error("commit_valid lane %0d set without lane %0d", lane, lane - 1);
    end

endmodule

bind rob_core_top rob_core_properties i_rob_core_properties (
    .clock        (clock),
    .reset        (reset),
    .inst_count   (inst_count),
    .inst_taken   (inst_taken),
    .commit_valid (commit_valid)
);

//--- test/rob_core_tb.sv
`timescale 1ns/1ns
`include "rob_core_params.svh"

module rob_core_tb;
    import rob_core_pkg::*;

    localparam int NUM_WORDS    = 300;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int WATCHDOG_NS  = NUM_WORDS * 5 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic                  clock = 1'b0;
    logic                  reset;
    inst_word_u            inst_word [`ROB_N] = '{default: '0};
    logic [`ROB_CNT_W-1:0] inst_count = '0;
    logic [`ROB_CNT_W-1:0] inst_taken;
    logic [`ROB_N-1:0]     commit_valid;
    logic [2:0]            commit_rd [`ROB_N];
    logic [`XLEN-1:0]      commit_value [`ROB_N];

    int                    seed = 32'h6887;
    inst_word_u            pending [$];                // Program words not yet taken.
    logic [2:0]            exp_rd [$];
    logic [`XLEN-1:0]      exp_value [$];
    logic [`XLEN-1:0]      model_regs [`NUM_REGS] = '{default: '0};
    int                    accepted = 0;

    rob_core_top i_rob_core_top (
        .clock        (clock),
        .reset        (reset),
        .inst_word    (inst_word),
        .inst_count   (inst_count),
        .inst_taken   (inst_taken),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [`XLEN-1:0] got,
                                   input logic [`XLEN-1:0] want);
        report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, want));
    endtask

    // Most picks land on r0 to r2 so the scoreboard sees plenty of hazards.
    function automatic logic [2:0] pick_reg();
        if (($random(seed) & 3) != 0) begin
            return 3'($unsigned($random(seed)) % 3);
        end
        return 3'($random(seed));
    endfunction

    task automatic add_random_word();
        inst_word_u w;
        op_e        op;
        op = op_e'($random(seed) & 7);
        if (op == ADDI || op == LUI) begin
            w.i_form.opcode = op;
            w.i_form.rd     = pick_reg();
            w.i_form.rs1    = pick_reg();
            w.i_form.imm    = 7'($random(seed));
        end else begin
            w.r_form.opcode = op;
            w.r_form.rd     = pick_reg();
            w.r_form.rs1    = pick_reg();
            w.r_form.rs2    = pick_reg();
            w.r_form.unused = 4'($random(seed));         // Decode must ignore these bits.
        end
        pending.push_back(w);
    endtask

    // Eight independent squares then two NOPs keep the ROB full for a while.
    task automatic add_mul_burst();
        inst_word_u w;
        for (int k = 0; k < `NUM_REGS + 2; k++) begin
            w.r_form.opcode = (k < `NUM_REGS) ? MUL : NOP;
            w.r_form.rd     = 3'(k);
            w.r_form.rs1    = 3'(k);
            w.r_form.rs2    = 3'(k);
            w.r_form.unused = '0;
            pending.push_back(w);
        end
    endtask

    // Sequential model of one instruction, run when the DUT takes it.
    task automatic model_accept(input inst_word_u w);
        op_e              op;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] result;
        op = w.r_form.opcode;
        a  = model_regs[w.r_form.rs1];
        b  = model_regs[w.r_form.rs2];
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            XOR:     result = a ^ b;
            MUL:     result = a * b;
            ADDI:    result = a + `XLEN'(int'(w.i_form.imm));
            LUI:     result = `XLEN'(w.i_form.imm) << 9;
            default: result = '0;
        endcase
        if (op != NOP) begin
            model_regs[w.r_form.rd] = result;
            exp_rd.push_back(w.r_form.rd);
            exp_value.push_back(result);
        end
        accepted++;
    endtask

    task automatic check_commit(input int lane);
        assert (exp_rd.size() > 0)
            else report_failure($sformatf("commit on lane %0d with nothing outstanding", lane));
        assert (commit_rd[lane] == exp_rd[0])
            else report_mismatch($sformatf("commit_rd[%0d]", lane), commit_rd[lane], exp_rd[0]);
        assert (commit_value[lane] == exp_value[0])
            else report_mismatch($sformatf("commit_value[%0d]", lane), commit_value[lane],
                                 exp_value[0]);
        void'(exp_rd.pop_front());
        void'(exp_value.pop_front());
    endtask

    always @(posedge clock) begin
        int offer;
        if (reset) begin
            inst_count <= '0;
        end else begin
            for (int lane = 0; lane < `ROB_N; lane++) begin
                if (commit_valid[lane]) begin
                    check_commit(lane);
                end
            end
            for (int k = 0; k < int'(inst_taken); k++) begin
                model_accept(pending.pop_front());
            end
            offer = (pending.size() < `ROB_N) ? pending.size() : `ROB_N;
            if (offer > 1 && ($random(seed) & 7) == 0) begin
                offer = 1;                              // A short group now and then.
            end
            for (int lane = 0; lane < `ROB_N; lane++) begin
                if (lane < offer) begin
                    inst_word[lane] <= pending[lane];
                end else begin
                    inst_word[lane] <= '0;
                end
            end
            inst_count <= `ROB_CNT_W'(offer);
        end
    end

    initial begin
        reset = 1'b1;
        while (pending.size() < NUM_WORDS) begin
            if (($random(seed) & 15) == 0) begin
                add_mul_burst();
            end else begin
                add_random_word();
            end
        end
        while (pending.size() > NUM_WORDS) begin
            void'(pending.pop_back());
        end
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        while (accepted < NUM_WORDS || exp_rd.size() != 0) begin
            @(posedge clock);
        end
        repeat (10) @(posedge clock);                   // Room for a stray extra commit.
        if (accepted == NUM_WORDS) begin
            $display("Everything OK");
            $finish;
        end else begin
            report_failure("more words were taken than the program holds");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure("timeout, commits stopped arriving before the program finished");
    end

endmodule

//--- rob_core.f
+incdir+hw
hw/rob_core_pkg.sv
hw/inst_decode.sv
hw/rob.sv
hw/alu_execute.sv
hw/retire.sv
hw/rob_core_top.sv
test/rob_core_properties.sv
test/rob_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rob_core_tb
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= rob_core.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
